/* rtl/rv32i_alu_pkg.sv */
package rv32i_alu_pkg;

  // station and bus sizes
  localparam int RS_DEPTH     = 8;
  localparam int RS_IDX_W     = 3;
  localparam int ROB_TAG_W    = 3;
  localparam int CDB_LANES    = 2;
  localparam int CDB_ALU_LANE = 0;

  typedef enum logic [6:0] {
    lui_opcode   = 7'b0110111,
    auipc_opcode = 7'b0010111,
    imm_opcode   = 7'b0010011,
    reg_opcode   = 7'b0110011
  } opcode_t;

  localparam logic [2:0] add_funct3  = 3'b000;
  localparam logic [2:0] sll_funct3  = 3'b001;
  localparam logic [2:0] slt_funct3  = 3'b010;
  localparam logic [2:0] sltu_funct3 = 3'b011;
  localparam logic [2:0] xor_funct3  = 3'b100;
  localparam logic [2:0] sr_funct3   = 3'b101;
  localparam logic [2:0] or_funct3   = 3'b110;
  localparam logic [2:0] and_funct3  = 3'b111;

  // sub and sra reuse the slt/sltu slots, which never reach the alu
  typedef enum logic [2:0] {
    add_alu_op = 3'b000,
    sll_alu_op = 3'b001,
    sra_alu_op = 3'b010,
    sub_alu_op = 3'b011,
    xor_alu_op = 3'b100,
    srl_alu_op = 3'b101,
    or_alu_op  = 3'b110,
    and_alu_op = 3'b111
  } alu_op_t;

  typedef enum logic [2:0] {
    blt_cmp_op  = 3'b100,
    bltu_cmp_op = 3'b110
  } cmp_op_t;

  typedef struct packed {
    opcode_t               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [31:0]           imm;
    logic [31:0]           pc;
    logic [ROB_TAG_W-1:0]  dest;
  } issue_t;

  // register file first, ROB second, tag names the producer otherwise
  typedef struct packed {
    logic                  regfile_ready;
    logic [31:0]           regfile_value;
    logic                  rob_ready;
    logic [31:0]           rob_value;
    logic [ROB_TAG_W-1:0]  tag;
  } src_lookup_t;

  typedef struct packed {
    logic                  ready;
    logic [31:0]           value;
    logic [ROB_TAG_W-1:0]  tag;
  } operand_t;

  typedef struct packed {
    opcode_t               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    operand_t              a;
    operand_t              b;
    logic [ROB_TAG_W-1:0]  dest;
  } rs_entry_t;

  typedef struct packed {
    logic                  valid;
    opcode_t               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [31:0]           a;
    logic [31:0]           b;
    logic [ROB_TAG_W-1:0]  dest;
  } exec_req_t;

  typedef struct packed {
    logic                  valid;
    logic [ROB_TAG_W-1:0]  tag;
    logic [31:0]           value;
  } cdb_lane_t;

  typedef cdb_lane_t [CDB_LANES-1:0] cdb_t;

endpackage

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu (
  input  rv32i_alu_pkg::alu_op_t op,
  input  logic [31:0]            a,
  input  logic [31:0]            b,
  output logic [31:0]            f
);
  import rv32i_alu_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      add_alu_op: f = a + b;
      sub_alu_op: f = a - b;
      sll_alu_op: f = a << shamt;
      srl_alu_op: f = a >> shamt;
      // arithmetic shift keeps the sign bit
      sra_alu_op: f = unsigned'($signed(a) >>> shamt);
      xor_alu_op: f = a ^ b;
      or_alu_op:  f = a | b;
      and_alu_op: f = a & b;
      default:    f = '0;
    endcase
  end

endmodule

/* rtl/cmp.sv */
`timescale 1ns/1ps

module cmp (
  input  rv32i_alu_pkg::cmp_op_t op,
  input  logic [31:0]            a,
  input  logic [31:0]            b,
  output logic                   lt
);
  import rv32i_alu_pkg::*;

  logic signed_lt;
  logic unsigned_lt;

  assign signed_lt   = $signed(a) < $signed(b);
  assign unsigned_lt = a < b;

  always_comb begin
    case (op)
      blt_cmp_op:  lt = signed_lt;
      bltu_cmp_op: lt = unsigned_lt;
      default:     lt = 1'b0;
    endcase
  end

endmodule

/* rtl/operand_capture.sv */
`timescale 1ns/1ps

module operand_capture (
  input  rv32i_alu_pkg::issue_t      issue_info,
  input  rv32i_alu_pkg::src_lookup_t src1,
  input  rv32i_alu_pkg::src_lookup_t src2,
  input  rv32i_alu_pkg::cdb_t        cdb,
  output rv32i_alu_pkg::rs_entry_t   new_entry
);
  import rv32i_alu_pkg::*;

  // register source: regfile, then ROB, then a lane broadcasting this cycle
  function automatic operand_t resolve(input src_lookup_t src, input cdb_t bus);
    operand_t op;
    op.ready = 1'b0;
    op.value = '0;
    op.tag   = src.tag;
    if (src.regfile_ready) begin
      op.ready = 1'b1;
      op.value = src.regfile_value;
    end else if (src.rob_ready) begin
      op.ready = 1'b1;
      op.value = src.rob_value;
    end else begin
      for (int i = 0; i < CDB_LANES; i++) begin
        if (bus[i].valid && bus[i].tag == src.tag) begin
          op.ready = 1'b1;
          op.value = bus[i].value;
        end
      end
    end
    return op;
  endfunction

  always_comb begin
    new_entry.opcode = issue_info.opcode;
    new_entry.funct3 = issue_info.funct3;
    new_entry.funct7 = issue_info.funct7;
    new_entry.dest   = issue_info.dest;
    new_entry.a      = resolve(src1, cdb);
    new_entry.b      = resolve(src2, cdb);
    case (issue_info.opcode)
      lui_opcode: begin
        new_entry.a = '{ready: 1'b1, value: '0, tag: '0};
        new_entry.b = '{ready: 1'b1, value: issue_info.imm, tag: '0};
      end
      auipc_opcode: begin
        new_entry.a = '{ready: 1'b1, value: issue_info.pc, tag: '0};
        new_entry.b = '{ready: 1'b1, value: issue_info.imm, tag: '0};
      end
      imm_opcode: begin
        new_entry.b = '{ready: 1'b1, value: issue_info.imm, tag: '0};
      end
      default: begin
        // reg-reg keeps both register sources
      end
    endcase
  end

endmodule

/* rtl/alu_rs.sv */
`timescale 1ns/1ps

module alu_rs (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     issue,
  input  rv32i_alu_pkg::rs_entry_t new_entry,
  input  rv32i_alu_pkg::cdb_t      cdb,
  output logic                     full,
  output rv32i_alu_pkg::exec_req_t exec_req
);
  import rv32i_alu_pkg::*;

  logic [RS_DEPTH-1:0] busy;
  rs_entry_t           entries [RS_DEPTH];

  // round-robin start point, one past the last pop
  logic [RS_IDX_W-1:0] rr_ptr;

  logic [RS_IDX_W-1:0] alloc_idx;
  logic                sel_valid;
  logic [RS_IDX_W-1:0] sel_idx;
  logic                do_issue;

  assign full     = &busy;
  assign do_issue = issue && !full;

  // lowest free slot wins
  always_comb begin
    alloc_idx = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        alloc_idx = RS_IDX_W'(i);
      end
    end
  end

  // first ready entry at or after rr_ptr, wrapping at the index width
  always_comb begin
    logic [RS_IDX_W-1:0] idx;
    sel_valid = 1'b0;
    sel_idx   = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      idx = rr_ptr + RS_IDX_W'(i);
      if (!sel_valid && busy[idx] && entries[idx].a.ready && entries[idx].b.ready) begin
        sel_valid = 1'b1;
        sel_idx   = idx;
      end
    end
  end

  always_comb begin
    exec_req.valid  = sel_valid;
    exec_req.opcode = entries[sel_idx].opcode;
    exec_req.funct3 = entries[sel_idx].funct3;
    exec_req.funct7 = entries[sel_idx].funct7;
    exec_req.a      = entries[sel_idx].a.value;
    exec_req.b      = entries[sel_idx].b.value;
    exec_req.dest   = entries[sel_idx].dest;
  end

  // busy bits and pointer
  always_ff @(posedge clk) begin
    if (rst) begin
      busy   <= '0;
      rr_ptr <= '0;
    end else begin
      if (do_issue) begin
        busy[alloc_idx] <= 1'b1;
      end
      if (sel_valid) begin
        busy[sel_idx] <= 1'b0;
        rr_ptr        <= sel_idx + RS_IDX_W'(1);
      end
    end
  end

  // entry payload and operand wakeup
  always_ff @(posedge clk) begin
    if (do_issue) begin
      entries[alloc_idx] <= new_entry;
    end
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (busy[i]) begin
        for (int j = 0; j < CDB_LANES; j++) begin
          if (cdb[j].valid && !entries[i].a.ready && cdb[j].tag == entries[i].a.tag) begin
            entries[i].a.ready <= 1'b1;
            entries[i].a.value <= cdb[j].value;
          end
          if (cdb[j].valid && !entries[i].b.ready && cdb[j].tag == entries[i].b.tag) begin
            entries[i].b.ready <= 1'b1;
            entries[i].b.value <= cdb[j].value;
          end
        end
      end
    end
  end

endmodule

/* rtl/alu_exec.sv */
`timescale 1ns/1ps

module alu_exec (
  input  logic                     clk,
  input  logic                     rst,
  input  rv32i_alu_pkg::exec_req_t req,
  output rv32i_alu_pkg::cdb_lane_t result
);
  import rv32i_alu_pkg::*;

  alu_op_t     alu_op;
  cmp_op_t     cmp_op;
  logic        use_cmp;
  logic [31:0] alu_f;
  logic        cmp_lt;
  logic [31:0] value;

  // opcode and funct fields to unit select
  always_comb begin
    alu_op  = add_alu_op;
    cmp_op  = blt_cmp_op;
    use_cmp = 1'b0;
    case (req.opcode)
      imm_opcode, reg_opcode: begin
        case (req.funct3)
          slt_funct3: begin
            use_cmp = 1'b1;
            cmp_op  = blt_cmp_op;
          end
          sltu_funct3: begin
            use_cmp = 1'b1;
            cmp_op  = bltu_cmp_op;
          end
          sr_funct3: alu_op = req.funct7[5] ? sra_alu_op : srl_alu_op;
          add_funct3: begin
            // immediate form has no subtract
            if (req.opcode == reg_opcode && req.funct7[5]) begin
              alu_op = sub_alu_op;
            end else begin
              alu_op = add_alu_op;
            end
          end
          default: alu_op = alu_op_t'(req.funct3);
        endcase
      end
      default: alu_op = add_alu_op;
    endcase
  end

  alu alu_inst (
    .op (alu_op),
    .a  (req.a),
    .b  (req.b),
    .f  (alu_f)
  );

  cmp cmp_inst (
    .op (cmp_op),
    .a  (req.a),
    .b  (req.b),
    .lt (cmp_lt)
  );

  assign value = use_cmp ? {31'b0, cmp_lt} : alu_f;

  always_ff @(posedge clk) begin
    if (rst) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= req.valid;
    end
  end

  always_ff @(posedge clk) begin
    result.tag   <= req.dest;
    result.value <= value;
  end

endmodule

/* rtl/alu_cluster_top.sv */
`timescale 1ns/1ps

module alu_cluster_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       issue,
  input  rv32i_alu_pkg::issue_t      issue_info,
  input  rv32i_alu_pkg::src_lookup_t src1,
  input  rv32i_alu_pkg::src_lookup_t src2,
  input  rv32i_alu_pkg::cdb_lane_t   ext_cdb,
  output logic                       full,
  output rv32i_alu_pkg::cdb_lane_t   cdb_out
);
  import rv32i_alu_pkg::*;

  cdb_t      cdb;
  rs_entry_t new_entry;
  exec_req_t exec_req;

  // own result on its lane, the other unit on the remaining one
  always_comb begin
    cdb                              = '0;
    cdb[CDB_ALU_LANE]                = cdb_out;
    cdb[CDB_LANES - 1 - CDB_ALU_LANE] = ext_cdb;
  end

  operand_capture operand_capture_inst (
    .issue_info (issue_info),
    .src1       (src1),
    .src2       (src2),
    .cdb        (cdb),
    .new_entry  (new_entry)
  );

  alu_rs alu_rs_inst (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .new_entry (new_entry),
    .cdb       (cdb),
    .full      (full),
    .exec_req  (exec_req)
  );

  alu_exec alu_exec_inst (
    .clk    (clk),
    .rst    (rst),
    .req    (exec_req),
    .result (cdb_out)
  );

endmodule

/* verification/alu_ref_model.svh */
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// expected result per tag, armed once every source value of the op is known
logic        exp_pending [1 << ROB_TAG_W];
logic [31:0] exp_value   [1 << ROB_TAG_W];
int          exp_due     [1 << ROB_TAG_W];

// RV32I semantics written out from the ISA rules
function automatic logic [31:0] ref_result(input opcode_t opc, input logic [2:0] f3,
                                           input logic [6:0] f7, input logic [31:0] a,
                                           input logic [31:0] b);
  logic [31:0] r;
  logic [4:0]  sh;
  sh = b[4:0];
  if (opc == lui_opcode || opc == auipc_opcode) begin
    return a + b;
  end
  case (f3)
    3'd0: r = (opc == reg_opcode && f7[5]) ? a - b : a + b;
    3'd1: r = a << sh;
    // signs differ means the negative one is smaller
    3'd2: r = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
    3'd3: r = {31'b0, a < b};
    3'd4: r = a ^ b;
    3'd5: r = f7[5] ? ((a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh))) : (a >> sh);
    3'd6: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

task automatic expect_tag(input logic [ROB_TAG_W-1:0] tag, input logic [31:0] value,
                          input int due);
  assert (!exp_pending[tag]) else fail_run("tag issued again while still outstanding");
  exp_pending[tag] = 1'b1;
  exp_value[tag]   = value;
  exp_due[tag]     = due;
endtask

function automatic int outstanding();
  int n;
  n = 0;
  for (int i = 0; i < (1 << ROB_TAG_W); i++) begin
    if (exp_pending[i]) begin
      n++;
    end
  end
  return n;
endfunction

`endif

/* verification/alu_cluster_tb.sv */
`timescale 1ns/1ps

module alu_cluster_tb;
  import rv32i_alu_pkg::*;

  logic        clk;
  logic        rst;
  logic        issue;
  issue_t      issue_info;
  src_lookup_t src1;
  src_lookup_t src2;
  cdb_lane_t   ext_cdb;
  logic        full;
  cdb_lane_t   cdb_out;
  int          cycle;
  logic        issued_any;

  alu_cluster_top alu_cluster_top_inst (
    .clk        (clk),
    .rst        (rst),
    .issue      (issue),
    .issue_info (issue_info),
    .src1       (src1),
    .src2       (src2),
    .ext_cdb    (ext_cdb),
    .full       (full),
    .cdb_out    (cdb_out)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
    fail_run("value mismatch");
  endtask

  `include "alu_ref_model.svh"

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // result checker, sampled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (!issued_any) begin
        assert (!full && !cdb_out.valid)
          else fail_run("full or cdb_out.valid high before first issue");
      end
      if (cdb_out.valid) begin
        assert (exp_pending[cdb_out.tag])
          else fail_run("cdb_out carries a tag with nothing outstanding");
        assert (cdb_out.value == exp_value[cdb_out.tag])
          else report_mismatch("cdb_out.value", exp_value[cdb_out.tag], cdb_out.value);
        assert (exp_due[cdb_out.tag] >= 0)
          else fail_run("cdb_out result arrived before its waiting source was released");
        assert (cycle == exp_due[cdb_out.tag])
          else report_mismatch("cdb_out.valid cycle", exp_due[cdb_out.tag], cycle);
        exp_pending[cdb_out.tag] = 1'b0;
      end
    end
  end

  // 0 lui, 1 auipc, 2..10 immediate ops, 11..18 register ops, 19 sra, 20 sub
  task automatic op_fields(input int idx, output opcode_t opc, output logic [2:0] f3,
                           output logic [6:0] f7);
    f7 = 7'h00;
    if (idx == 0) begin
      opc = lui_opcode;
      f3  = 3'd0;
    end else if (idx == 1) begin
      opc = auipc_opcode;
      f3  = 3'd0;
    end else if (idx <= 10) begin
      opc = imm_opcode;
      f3  = (idx == 10) ? 3'd5 : 3'(idx - 2);
      if (idx == 10) begin
        f7 = 7'h20;
      end
    end else begin
      opc = reg_opcode;
      if (idx == 19) begin
        f3 = 3'd5;
      end else if (idx == 20) begin
        f3 = 3'd0;
      end else begin
        f3 = 3'(idx - 11);
      end
      if (idx >= 19) begin
        f7 = 7'h20;
      end
    end
  endtask

  function automatic src_lookup_t make_src(input logic waits, input logic [ROB_TAG_W-1:0] tag,
                                           input logic [31:0] value);
    src_lookup_t s;
    logic        from_rob;
    from_rob        = $urandom % 2 == 1;
    s.tag           = tag;
    s.regfile_ready = !waits && !from_rob;
    s.regfile_value = (!waits && !from_rob) ? value : $urandom;
    s.rob_ready     = !waits && from_rob;
    s.rob_value     = (!waits && from_rob) ? value : $urandom;
    return s;
  endfunction

  // due_rel below zero marks a result that must wait until a release arms it
  task automatic issue_op(input int idx, input logic [ROB_TAG_W-1:0] dest,
                          input logic a_wait, input logic [ROB_TAG_W-1:0] a_tag,
                          input logic [31:0] a_val, input logic b_wait,
                          input logic [ROB_TAG_W-1:0] b_tag, input logic [31:0] b_val,
                          input int due_rel, output logic [31:0] exp);
    opcode_t     opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm;
    logic [31:0] a_eff;
    op_fields(idx, opc, f3, f7);
    imm = {{20{b_val[11]}}, b_val[11:0]};
    if (opc == lui_opcode || opc == auipc_opcode) begin
      imm = {b_val[31:12], 12'b0};
    end else if (opc == imm_opcode) begin
      if (f3 == 3'd1 || f3 == 3'd5) begin
        imm[11:5] = f7;
      end
      f7 = imm[11:5];
    end
    a_eff = (opc == lui_opcode) ? 32'd0 : a_val;
    exp   = ref_result(opc, f3, f7, a_eff, (opc == reg_opcode) ? b_val : imm);
    expect_tag(dest, exp, (due_rel >= 0) ? cycle + due_rel : -1);
    assert (!full) else fail_run("issue needed while the station is full");
    issue_info = '{opcode: opc, funct3: f3, funct7: f7, imm: imm, pc: a_val, dest: dest};
    src1       = make_src(a_wait, a_tag, a_val);
    src2       = make_src(b_wait, b_tag, b_val);
    issue      = 1'b1;
    issued_any = 1'b1;
    @(negedge clk);
    issue = 1'b0;
  endtask

  task automatic release_tag(input logic [ROB_TAG_W-1:0] tag, input logic [31:0] value);
    ext_cdb = '{valid: 1'b1, tag: tag, value: value};
    @(negedge clk);
    ext_cdb.valid = 1'b0;
  endtask

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    while (outstanding() != 0) begin
      if (n == limit) begin
        fail_run("timeout waiting for outstanding results on cdb_out");
      end
      @(negedge clk);
      n++;
    end
  endtask

  initial begin
    logic [31:0]          v;
    logic [31:0]          rel_val [8];
    logic [ROB_TAG_W-1:0] order [8];
    logic [ROB_TAG_W-1:0] t;
    int                   j;
    void'($urandom(97));
    rst = 1'b1;
    issue = 1'b0;
    issue_info = '0;
    src1 = '0;
    src2 = '0;
    ext_cdb = '0;
    cycle = 0;
    issued_any = 1'b0;
    for (int i = 0; i < 8; i++) begin
      exp_pending[i] = 1'b0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (3) @(negedge clk);

    // every op once, then random ops, all sources ready
    for (int i = 0; i < 45; i++) begin
      issue_op((i < 21) ? i : int'($urandom % 21), 3'(i), 0, 0, $urandom, 0, 0, $urandom, 2, v);
    end
    wait_idle(20);

    // both operands woken by the external lane
    rel_val[0] = $urandom;
    rel_val[1] = $urandom;
    issue_op(17, 3'd2, 1, 3'd5, rel_val[0], 1, 3'd6, rel_val[1], -1, v);
    repeat (2) @(negedge clk);
    release_tag(3'd5, rel_val[0]);
    exp_due[2] = cycle + 2;
    release_tag(3'd6, rel_val[1]);
    wait_idle(20);

    // chain through the cluster's own lane
    issue_op(2, 3'd0, 0, 0, $urandom, 0, 0, $urandom, 2, v);
    for (int k = 1; k < 4; k++) begin
      issue_op(11 + int'($urandom % 10), 3'(k), 1, 3'(k - 1), v, 0, 0, $urandom, 2 + k, v);
    end
    wait_idle(20);

    // source captured from a lane valid in the issue cycle
    rel_val[0] = $urandom;
    ext_cdb = '{valid: 1'b1, tag: 3'd4, value: rel_val[0]};
    issue_op(11, 3'd1, 1, 3'd4, rel_val[0], 0, 0, $urandom, 2, v);
    ext_cdb.valid = 1'b0;
    wait_idle(20);

    // fill the station, then release in random order
    for (int i = 0; i < 8; i++) begin
      rel_val[i] = $urandom;
      order[i]   = 3'(i);
      issue_op(11 + int'($urandom % 10), 3'(i), 1, 3'(i), rel_val[i], 0, 0, $urandom, -1, v);
    end
    assert (full) else report_mismatch("full", 1, 0);
    for (int i = 7; i > 0; i--) begin
      j = int'($urandom % (i + 1));
      t = order[i];
      order[i] = order[j];
      order[j] = t;
    end
    for (int i = 0; i < 8; i++) begin
      exp_due[order[i]] = cycle + 2;
      release_tag(order[i], rel_val[order[i]]);
      // first pop lands at the end of this cycle
      if (i == 0) begin
        assert (full) else report_mismatch("full", 1, 0);
      end
      if (i == 1) begin
        assert (!full) else report_mismatch("full", 0, 1);
      end
    end
    wait_idle(20);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* sim.f */
+incdir+verification
rtl/rv32i_alu_pkg.sv
rtl/alu.sv
rtl/cmp.sv
rtl/operand_capture.sv
rtl/alu_rs.sv
rtl/alu_exec.sv
rtl/alu_cluster_top.sv
verification/alu_cluster_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := alu_cluster_tb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
